/* src/ace_kbd_params.svh */
`ifndef ACE_KBD_PARAMS_SVH
`define ACE_KBD_PARAMS_SVH

////////////////////////////////////////////////////////////
// Jupiter Ace matrix geometry
////////////////////////////////////////////////////////////

`define ACE_ROWS        8       // Width of rows
`define ACE_COLS        5       // Width of columns
`define ACE_ROW_W       3
`define ACE_COL_W       3

////////////////////////////////////////////////////////////
// PS/2 receiver
////////////////////////////////////////////////////////////

// Clock glitch filter depth in clk samples
`define PS2_FILTER_LEN  8

// Idle clk cycles before a partial frame is dropped
`define PS2_TIMEOUT     4096
`define PS2_TIMEOUT_W   13

`endif

/* src/ace_kbd_pkg.sv */
`default_nettype none

`include "ace_kbd_params.svh"

package ace_kbd_pkg;

    ////////////////////////////////////////////////////////////
    // PS/2 set 2 scancodes
    ////////////////////////////////////////////////////////////

    localparam logic [7:0] SC_BREAK = 8'hF0, SC_EXT = 8'hE0;
    localparam logic [7:0] SC_LSHIFT = 8'h12, SC_RSHIFT = 8'h59, SC_CTRL = 8'h14;
    localparam logic [7:0] SC_ALT = 8'h11, SC_F5 = 8'h03, SC_KPDOT = 8'h71;
    localparam logic [7:0] SC_ENTER = 8'h5A, SC_ESC = 8'h76, SC_BKSP = 8'h66;
    localparam logic [7:0] SC_SPACE = 8'h29;

    localparam logic [7:0] SC_A = 8'h1C, SC_B = 8'h32, SC_C = 8'h21, SC_D = 8'h23;
    localparam logic [7:0] SC_E = 8'h24, SC_F = 8'h2B, SC_G = 8'h34, SC_H = 8'h33;
    localparam logic [7:0] SC_I = 8'h43, SC_J = 8'h3B, SC_K = 8'h42, SC_L = 8'h4B;
    localparam logic [7:0] SC_M = 8'h3A, SC_N = 8'h31, SC_O = 8'h44, SC_P = 8'h4D;
    localparam logic [7:0] SC_Q = 8'h15, SC_R = 8'h2D, SC_S = 8'h1B, SC_T = 8'h2C;
    localparam logic [7:0] SC_U = 8'h3C, SC_V = 8'h2A, SC_W = 8'h1D, SC_X = 8'h22;
    localparam logic [7:0] SC_Y = 8'h35, SC_Z = 8'h1A;

    localparam logic [7:0] SC_0 = 8'h45, SC_1 = 8'h16, SC_2 = 8'h1E, SC_3 = 8'h26;
    localparam logic [7:0] SC_4 = 8'h25, SC_5 = 8'h2E, SC_6 = 8'h36, SC_7 = 8'h3D;
    localparam logic [7:0] SC_8 = 8'h3E, SC_9 = 8'h46;

    // Only valid after E0
    localparam logic [7:0] SC_UP = 8'h75, SC_DOWN = 8'h72;
    localparam logic [7:0] SC_LEFT = 8'h6B, SC_RIGHT = 8'h74;

    ////////////////////////////////////////////////////////////
    // Ace matrix positions
    ////////////////////////////////////////////////////////////

    localparam int POS_W = `ACE_ROW_W + `ACE_COL_W;

    // Two octal digits, row then column
    localparam logic [POS_W-1:0] POS_CAPS = 6'o00, POS_SYM = 6'o01;
    localparam logic [POS_W-1:0] POS_Z = 6'o02, POS_X = 6'o03, POS_C = 6'o04;
    localparam logic [POS_W-1:0] POS_A = 6'o10, POS_S = 6'o11, POS_D = 6'o12;
    localparam logic [POS_W-1:0] POS_F = 6'o13, POS_G = 6'o14;
    localparam logic [POS_W-1:0] POS_Q = 6'o20, POS_W_KEY = 6'o21, POS_E = 6'o22;
    localparam logic [POS_W-1:0] POS_R = 6'o23, POS_T = 6'o24;
    localparam logic [POS_W-1:0] POS_1 = 6'o30, POS_2 = 6'o31, POS_3 = 6'o32;
    localparam logic [POS_W-1:0] POS_4 = 6'o33, POS_5 = 6'o34;
    localparam logic [POS_W-1:0] POS_0 = 6'o40, POS_9 = 6'o41, POS_8 = 6'o42;
    localparam logic [POS_W-1:0] POS_7 = 6'o43, POS_6 = 6'o44;
    localparam logic [POS_W-1:0] POS_P = 6'o50, POS_O = 6'o51, POS_I = 6'o52;
    localparam logic [POS_W-1:0] POS_U = 6'o53, POS_Y = 6'o54;
    localparam logic [POS_W-1:0] POS_ENTER = 6'o60, POS_L = 6'o61, POS_K = 6'o62;
    localparam logic [POS_W-1:0] POS_J = 6'o63, POS_H = 6'o64;
    localparam logic [POS_W-1:0] POS_SPACE = 6'o70, POS_M = 6'o71, POS_N = 6'o72;
    localparam logic [POS_W-1:0] POS_B = 6'o73, POS_V = 6'o74;

endpackage

`default_nettype wire

/* src/ps2_rx.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ace_kbd_params.svh"

module ps2_rx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    output logic       byte_valid,
    output logic [7:0] rx_byte
);

    logic [1:0]                    clk_sync;
    logic [1:0]                    data_sync;
    logic [`PS2_FILTER_LEN-1:0]    filt_sr;
    logic                          clk_filt;
    logic                          fall;
    logic [3:0]                    bit_cnt;
    logic [9:0]                    shift_reg;
    logic [10:0]                   frame;
    logic                          frame_ok;
    logic [`PS2_TIMEOUT_W-1:0]     timer;

    ////////////////////////////////////////////////////////////
    // Synchronizers and clock filter
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            clk_sync  <= 2'b11;
            data_sync <= 2'b11;
            filt_sr   <= '1;
            clk_filt  <= 1'b1;
        end
        else
        begin
            clk_sync  <= {clk_sync[0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
            filt_sr   <= {filt_sr[`PS2_FILTER_LEN-2:0], clk_sync[1]};
            if (filt_sr == '1)
                clk_filt <= 1'b1;
            else if (filt_sr == '0)
                clk_filt <= 1'b0;
        end
    end

    assign fall = clk_filt && (filt_sr == '0);  // Filtered falling edge

    ////////////////////////////////////////////////////////////
    // Frame assembly
    ////////////////////////////////////////////////////////////

    // {stop, parity, data[7:0], start}
    assign frame    = {data_sync[1], shift_reg};
    assign frame_ok = !frame[0] && frame[10] && (^frame[9:1]);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            bit_cnt    <= '0;
            timer      <= '0;
            byte_valid <= 1'b0;
        end
        else
        begin
            byte_valid <= 1'b0;
            if (fall)
            begin
                timer <= '0;
                if (bit_cnt == 4'd10)
                begin
                    bit_cnt    <= '0;
                    byte_valid <= frame_ok;
                end
                else
                    bit_cnt <= bit_cnt + 4'd1;
            end
            else if (bit_cnt != '0)
            begin
                if (timer == `PS2_TIMEOUT_W'(`PS2_TIMEOUT))
                begin
                    bit_cnt <= '0;  // Drop partial frame
                    timer   <= '0;
                end
                else
                    timer <= timer + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (fall)
        begin
            shift_reg <= {data_sync[1], shift_reg[9:1]};  // LSB first
            if (bit_cnt == 4'd10)
                rx_byte <= frame[8:1];
        end
    end

    a_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        byte_valid |=> !byte_valid);

endmodule

`default_nettype wire

/* src/scancode_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module scancode_decoder
    import ace_kbd_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       byte_valid,
    input  logic [7:0] rx_byte,
    output logic       key_valid,
    output logic [7:0] key_code,
    output logic       key_released,
    output logic       key_extended
);

    logic brk_flag;
    logic ext_flag;
    logic is_prefix;

    assign is_prefix = (rx_byte == SC_BREAK) || (rx_byte == SC_EXT);

    ////////////////////////////////////////////////////////////
    // Prefix flags and event strobe
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            brk_flag  <= 1'b0;
            ext_flag  <= 1'b0;
            key_valid <= 1'b0;
        end
        else
        begin
            key_valid <= byte_valid && !is_prefix;
            if (byte_valid)
            begin
                if (rx_byte == SC_BREAK)
                    brk_flag <= 1'b1;
                else if (rx_byte == SC_EXT)
                    ext_flag <= 1'b1;
                else
                begin
                    // Event consumes both prefixes
                    brk_flag <= 1'b0;
                    ext_flag <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (byte_valid && !is_prefix)
        begin
            key_code     <= rx_byte;
            key_released <= brk_flag;
            key_extended <= ext_flag;
        end
    end

endmodule

`default_nettype wire

/* src/key_mapper.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ace_kbd_params.svh"

module key_mapper
    import ace_kbd_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  key_valid,
    input  logic [7:0]            key_code,
    input  logic                  key_released,
    input  logic                  key_extended,
    output logic                  set_valid,
    output logic                  set_released,
    output logic [`ACE_ROW_W-1:0] set_row,
    output logic [`ACE_COL_W-1:0] set_col,
    output logic                  caps_en,
    output logic                  sym_en,
    output logic                  clear_all,
    output logic                  kbd_reset,
    output logic                  kbd_nmi
);

    logic             shift_on;
    logic             ctrl_on;
    logic             alt_on;
    logic             map_hit;
    logic [POS_W-1:0] map_pos;
    logic             map_caps;
    logic             map_sym;

    ////////////////////////////////////////////////////////////
    // Key lookup
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        map_hit  = 1'b1;
        map_pos  = POS_CAPS;
        map_caps = 1'b0;
        map_sym  = 1'b0;
        case ({key_extended, key_code})
            {1'b0, SC_A}: {map_pos, map_caps} = {POS_A, shift_on};
            {1'b0, SC_B}: {map_pos, map_caps} = {POS_B, shift_on};
            {1'b0, SC_C}: {map_pos, map_caps} = {POS_C, shift_on};
            {1'b0, SC_D}: {map_pos, map_caps} = {POS_D, shift_on};
            {1'b0, SC_E}: {map_pos, map_caps} = {POS_E, shift_on};
            {1'b0, SC_F}: {map_pos, map_caps} = {POS_F, shift_on};
            {1'b0, SC_G}: {map_pos, map_caps} = {POS_G, shift_on};
            {1'b0, SC_H}: {map_pos, map_caps} = {POS_H, shift_on};
            {1'b0, SC_I}: {map_pos, map_caps} = {POS_I, shift_on};
            {1'b0, SC_J}: {map_pos, map_caps} = {POS_J, shift_on};
            {1'b0, SC_K}: {map_pos, map_caps} = {POS_K, shift_on};
            {1'b0, SC_L}: {map_pos, map_caps} = {POS_L, shift_on};
            {1'b0, SC_M}: {map_pos, map_caps} = {POS_M, shift_on};
            {1'b0, SC_N}: {map_pos, map_caps} = {POS_N, shift_on};
            {1'b0, SC_O}: {map_pos, map_caps} = {POS_O, shift_on};
            {1'b0, SC_P}: {map_pos, map_caps} = {POS_P, shift_on};
            {1'b0, SC_Q}: {map_pos, map_caps} = {POS_Q, shift_on};
            {1'b0, SC_R}: {map_pos, map_caps} = {POS_R, shift_on};
            {1'b0, SC_S}: {map_pos, map_caps} = {POS_S, shift_on};
            {1'b0, SC_T}: {map_pos, map_caps} = {POS_T, shift_on};
            {1'b0, SC_U}: {map_pos, map_caps} = {POS_U, shift_on};
            {1'b0, SC_V}: {map_pos, map_caps} = {POS_V, shift_on};
            {1'b0, SC_W}: {map_pos, map_caps} = {POS_W_KEY, shift_on};
            {1'b0, SC_X}: {map_pos, map_caps} = {POS_X, shift_on};
            {1'b0, SC_Y}: {map_pos, map_caps} = {POS_Y, shift_on};
            {1'b0, SC_Z}: {map_pos, map_caps} = {POS_Z, shift_on};
            // Shifted digits go through Symbol Shift
            {1'b0, SC_0}: {map_pos, map_sym} = {POS_0, shift_on};
            {1'b0, SC_1}: {map_pos, map_sym} = {POS_1, shift_on};
            {1'b0, SC_2}: {map_pos, map_sym} = {POS_2, shift_on};
            {1'b0, SC_3}: {map_pos, map_sym} = {POS_3, shift_on};
            {1'b0, SC_4}: {map_pos, map_sym} = {POS_4, shift_on};
            {1'b0, SC_5}: {map_pos, map_sym} = {POS_5, shift_on};
            {1'b0, SC_6}: {map_pos, map_sym} = {POS_6, shift_on};
            {1'b0, SC_7}: {map_pos, map_sym} = {POS_7, shift_on};
            {1'b0, SC_8}: {map_pos, map_sym} = {POS_8, shift_on};
            {1'b0, SC_9}: {map_pos, map_sym} = {POS_9, shift_on};
            {1'b0, SC_SPACE}: map_pos = POS_SPACE;
            {1'b0, SC_ENTER}: map_pos = POS_ENTER;
            {1'b0, SC_ESC}:   {map_pos, map_caps} = {POS_SPACE, 1'b1};  // Break
            {1'b0, SC_BKSP}:  {map_pos, map_caps} = {POS_0, 1'b1};      // Delete
            {1'b1, SC_UP}:    {map_pos, map_caps} = {POS_6, 1'b1};
            {1'b1, SC_DOWN}:  {map_pos, map_caps} = {POS_7, 1'b1};
            {1'b1, SC_LEFT}:  {map_pos, map_caps} = {POS_5, 1'b1};
            {1'b1, SC_RIGHT}: {map_pos, map_caps} = {POS_8, 1'b1};
            default: map_hit = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Modifiers and system combos
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            shift_on  <= 1'b0;
            ctrl_on   <= 1'b0;
            alt_on    <= 1'b0;
            set_valid <= 1'b0;
            clear_all <= 1'b0;
            kbd_reset <= 1'b1;
            kbd_nmi   <= 1'b1;
        end
        else
        begin
            set_valid <= key_valid && map_hit;
            clear_all <= 1'b0;
            if (key_valid)
            begin
                case (key_code)
                    SC_LSHIFT,
                    SC_RSHIFT: shift_on <= !key_released && !key_extended;  // Skip fake shifts
                    SC_CTRL:   ctrl_on  <= !key_released;
                    SC_ALT:    alt_on   <= !key_released;
                    SC_KPDOT:
                        if (key_released)
                            kbd_reset <= 1'b1;
                        else if (ctrl_on && alt_on && !key_extended)
                        begin
                            kbd_reset <= 1'b0;
                            clear_all <= 1'b1;
                        end
                    SC_F5:
                        if (key_released)
                            kbd_nmi <= 1'b1;
                        else if (ctrl_on && alt_on)
                            kbd_nmi <= 1'b0;
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (key_valid)
        begin
            set_released <= key_released;
            set_row      <= map_pos[POS_W-1 -: `ACE_ROW_W];
            set_col      <= map_pos[`ACE_COL_W-1:0];
            caps_en      <= map_caps;
            sym_en       <= map_sym;
        end
    end

    a_no_clear_with_set: assert property (@(posedge clk) disable iff (!rst_n)
        !(clear_all && set_valid));

endmodule

`default_nettype wire

/* src/key_matrix.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ace_kbd_params.svh"

module key_matrix
    import ace_kbd_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  set_valid,
    input  logic                  set_released,
    input  logic [`ACE_ROW_W-1:0] set_row,
    input  logic [`ACE_COL_W-1:0] set_col,
    input  logic                  caps_en,
    input  logic                  sym_en,
    input  logic                  clear_all,
    input  logic [`ACE_ROWS-1:0]  rows,
    output logic [`ACE_COLS-1:0]  columns
);

    logic [`ACE_COLS-1:0] matrix [`ACE_ROWS];  // 0 = pressed

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int r = 0; r < `ACE_ROWS; r++)
                matrix[r] <= '1;
        end
        else if (clear_all)
        begin
            for (int r = 0; r < `ACE_ROWS; r++)
                matrix[r] <= '1;
        end
        else if (set_valid)
        begin
            matrix[set_row][set_col] <= set_released;
            if (caps_en)
                matrix[POS_CAPS[POS_W-1 -: `ACE_ROW_W]][POS_CAPS[`ACE_COL_W-1:0]] <= set_released;
            if (sym_en)
                matrix[POS_SYM[POS_W-1 -: `ACE_ROW_W]][POS_SYM[`ACE_COL_W-1:0]] <= set_released;
        end
    end

    // Scanned rows are low
    always_comb
    begin
        columns = '1;
        for (int r = 0; r < `ACE_ROWS; r++)
        begin
            if (!rows[r])
                columns = columns & matrix[r];
        end
    end

    // Mapper only produces real columns
    a_col_range: assert property (@(posedge clk) disable iff (!rst_n)
        set_valid |-> (set_col < `ACE_COL_W'(`ACE_COLS)));

endmodule

`default_nettype wire

/* src/ace_keyboard.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ace_kbd_params.svh"

module ace_keyboard (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 ps2_clk,
    input  logic                 ps2_data,
    input  logic [`ACE_ROWS-1:0] rows,
    output logic [`ACE_COLS-1:0] columns,
    output logic                 kbd_reset,
    output logic                 kbd_nmi
);

    logic                  byte_valid;
    logic [7:0]            rx_byte;
    logic                  key_valid;
    logic [7:0]            key_code;
    logic                  key_released;
    logic                  key_extended;
    logic                  set_valid;
    logic                  set_released;
    logic [`ACE_ROW_W-1:0] set_row;
    logic [`ACE_COL_W-1:0] set_col;
    logic                  caps_en;
    logic                  sym_en;
    logic                  clear_all;

    ////////////////////////////////////////////////////////////
    // PS/2 bytes to key events
    ////////////////////////////////////////////////////////////

    ps2_rx ps2_rx_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .byte_valid (byte_valid),
        .rx_byte    (rx_byte)
    );

    scancode_decoder scancode_decoder_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .byte_valid   (byte_valid),
        .rx_byte      (rx_byte),
        .key_valid    (key_valid),
        .key_code     (key_code),
        .key_released (key_released),
        .key_extended (key_extended)
    );

    ////////////////////////////////////////////////////////////
    // Key events to the Ace matrix
    ////////////////////////////////////////////////////////////

    key_mapper key_mapper_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .key_valid    (key_valid),
        .key_code     (key_code),
        .key_released (key_released),
        .key_extended (key_extended),
        .set_valid    (set_valid),
        .set_released (set_released),
        .set_row      (set_row),
        .set_col      (set_col),
        .caps_en      (caps_en),
        .sym_en       (sym_en),
        .clear_all    (clear_all),
        .kbd_reset    (kbd_reset),
        .kbd_nmi      (kbd_nmi)
    );

    key_matrix key_matrix_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .set_valid    (set_valid),
        .set_released (set_released),
        .set_row      (set_row),
        .set_col      (set_col),
        .caps_en      (caps_en),
        .sym_en       (sym_en),
        .clear_all    (clear_all),
        .rows         (rows),
        .columns      (columns)
    );

endmodule

`default_nettype wire

/* verification/ace_keyboard_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ace_kbd_params.svh"

module ace_keyboard_tb
    import ace_kbd_pkg::*;
();

    localparam int HALF_BIT = 20;   // clk per PS/2 half bit
    localparam int KEY_GAP  = 20;

    // About 90 bytes at 1.8 us plus one 17 us timeout gap, so about 180 us
    localparam int WATCHDOG_NS = 400_000;

    logic                 clk;
    logic                 rst_n;
    logic                 ps2_clk;
    logic                 ps2_data;
    logic [`ACE_ROWS-1:0] rows;
    logic [`ACE_COLS-1:0] columns;
    logic                 kbd_reset;
    logic                 kbd_nmi;

    logic [`ACE_COLS-1:0] pressed [`ACE_ROWS];  // 1 = key down
    string                test_name;

    ace_keyboard dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .ps2_clk   (ps2_clk),
        .ps2_data  (ps2_data),
        .rows      (rows),
        .columns   (columns),
        .kbd_reset (kbd_reset),
        .kbd_nmi   (kbd_nmi)
    );

    initial
        clk = 1'b0;
    always #2 clk = ~clk;

    initial
    begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish in time");
        $display("Simulation FAILED");
        $fatal(1, "Watchdog expired");
    end

    ////////////////////////////////////////////////////////////
    // Checking
    ////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("ERROR: %s expected %0h actual %0h", name, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    task automatic check_columns(input string name, input logic [`ACE_ROWS-1:0] pat);
        logic [`ACE_COLS-1:0] expected;
        expected = '1;
        for (int r = 0; r < `ACE_ROWS; r++)
            if (!pat[3'(r)])
                expected = expected & ~pressed[3'(r)];
        @(negedge clk);
        rows = pat;
        #1;
        check_value($sformatf("%s rows=%b", name, pat), 32'(expected), 32'(columns));
    endtask

    // All rows, no rows, then each row alone
    task automatic check_matrix(input string name);
        check_columns(name, '0);
        check_columns(name, '1);
        for (int r = 0; r < `ACE_ROWS; r++)
            check_columns(name, ~(8'd1 << r));
    endtask

    task automatic check_outputs(input string name, input logic exp_reset, input logic exp_nmi);
        check_value({name, " kbd_reset"}, 32'(exp_reset), 32'(kbd_reset));
        check_value({name, " kbd_nmi"}, 32'(exp_nmi), 32'(kbd_nmi));
    endtask

    task automatic clear_model();
        for (int r = 0; r < `ACE_ROWS; r++)
            pressed[r] = '0;
    endtask

    ////////////////////////////////////////////////////////////
    // PS/2 keyboard side
    ////////////////////////////////////////////////////////////

    task automatic send_bit(input logic b);
        ps2_data = b;
        repeat (HALF_BIT) @(negedge clk);
        ps2_clk = 1'b0;                     // Host samples on this edge
        repeat (HALF_BIT) @(negedge clk);
        ps2_clk = 1'b1;
    endtask

    task automatic send_byte(input logic [7:0] data, input logic bad_parity);
        logic parity;
        parity = ~(^data) ^ bad_parity;     // Odd parity
        @(negedge clk);
        send_bit(1'b0);
        for (int i = 0; i < 8; i++)
            send_bit(data[i]);
        send_bit(parity);
        send_bit(1'b1);
        ps2_data = 1'b1;
        repeat (HALF_BIT) @(negedge clk);
    endtask

    task automatic press_key(input logic [7:0] sc, input logic ext);
        if (ext)
            send_byte(SC_EXT, 1'b0);
        send_byte(sc, 1'b0);
        repeat (KEY_GAP) @(negedge clk);
    endtask

    task automatic release_key(input logic [7:0] sc, input logic ext);
        if (ext)
            send_byte(SC_EXT, 1'b0);
        send_byte(SC_BREAK, 1'b0);
        send_byte(sc, 1'b0);
        repeat (KEY_GAP) @(negedge clk);
    endtask

    // Press, check, release, check
    task automatic tap_key(input logic [7:0] sc, input logic ext, input logic [2:0] row,
                           input logic [2:0] col, input logic caps);
        press_key(sc, ext);
        pressed[row][col] = 1'b1;
        if (caps)
            pressed[0][0] = 1'b1;
        check_matrix($sformatf("%s key %h", test_name, sc));
        release_key(sc, ext);
        clear_model();
        check_matrix($sformatf("%s key %h released", test_name, sc));
    endtask

    task automatic check_unmapped(input logic [7:0] sc);
        press_key(sc, 1'b0);
        check_matrix($sformatf("%s plain %h", test_name, sc));
        release_key(sc, 1'b0);
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic plain_keys();
        test_name = "plain_keys";
        check_outputs(test_name, 1'b1, 1'b1);
        check_matrix(test_name);
        tap_key(SC_A, 1'b0, 3'd1, 3'd0, 1'b0);
        tap_key(SC_SPACE, 1'b0, 3'd7, 3'd0, 1'b0);
        tap_key(SC_ENTER, 1'b0, 3'd6, 3'd0, 1'b0);
        tap_key(SC_7, 1'b0, 3'd4, 3'd3, 1'b0);
    endtask

    task automatic shift_mapping();
        test_name = "shift";
        press_key(SC_LSHIFT, 1'b0);
        press_key(SC_Z, 1'b0);
        pressed[0][2] = 1'b1;
        pressed[0][0] = 1'b1;               // Caps Shift
        check_matrix({test_name, " shift+z"});
        release_key(SC_Z, 1'b0);
        release_key(SC_LSHIFT, 1'b0);
        clear_model();
        check_matrix({test_name, " z released"});
        press_key(SC_RSHIFT, 1'b0);
        press_key(SC_3, 1'b0);
        pressed[3][2] = 1'b1;
        pressed[0][1] = 1'b1;               // Symbol Shift
        check_matrix({test_name, " shift+3"});
        release_key(SC_3, 1'b0);
        release_key(SC_RSHIFT, 1'b0);
        clear_model();
        check_matrix({test_name, " 3 released"});
    endtask

    task automatic composite_keys();
        test_name = "composite";
        tap_key(SC_BKSP, 1'b0, 3'd4, 3'd0, 1'b1);
        tap_key(SC_ESC, 1'b0, 3'd7, 3'd0, 1'b1);
        tap_key(SC_UP, 1'b1, 3'd4, 3'd4, 1'b1);
        tap_key(SC_DOWN, 1'b1, 3'd4, 3'd3, 1'b1);
        tap_key(SC_LEFT, 1'b1, 3'd3, 3'd4, 1'b1);
        tap_key(SC_RIGHT, 1'b1, 3'd4, 3'd2, 1'b1);
        // Keypad codes without E0
        check_unmapped(SC_UP);
        check_unmapped(SC_DOWN);
        check_unmapped(SC_LEFT);
        check_unmapped(SC_RIGHT);
    endtask

    task automatic simultaneous_keys();
        test_name = "simultaneous";
        press_key(SC_Q, 1'b0);
        press_key(SC_P, 1'b0);
        pressed[2][0] = 1'b1;
        pressed[5][0] = 1'b1;
        check_matrix({test_name, " q+p"});
        release_key(SC_Q, 1'b0);
        pressed[2][0] = 1'b0;
        check_matrix({test_name, " p only"});
        release_key(SC_P, 1'b0);
        clear_model();
        check_matrix({test_name, " none"});
    endtask

    task automatic corrupted_frames();
        test_name = "corrupt";
        send_byte(SC_A, 1'b1);
        repeat (KEY_GAP) @(negedge clk);
        check_matrix({test_name, " bad parity"});
        @(negedge clk);
        send_bit(1'b0);
        send_bit(1'b1);
        send_bit(1'b0);
        ps2_data = 1'b1;
        repeat (`PS2_TIMEOUT + 200) @(negedge clk);
        check_matrix({test_name, " partial frame"});
        tap_key(SC_B, 1'b0, 3'd7, 3'd3, 1'b0);
    endtask

    task automatic system_combos();
        test_name = "system";
        press_key(SC_Q, 1'b0);
        pressed[2][0] = 1'b1;
        check_matrix({test_name, " q held"});
        press_key(SC_CTRL, 1'b0);
        press_key(SC_ALT, 1'b0);
        press_key(SC_KPDOT, 1'b0);
        check_outputs({test_name, " reset combo"}, 1'b0, 1'b1);
        clear_model();
        check_matrix({test_name, " cleared"});
        release_key(SC_KPDOT, 1'b0);
        check_outputs({test_name, " reset released"}, 1'b1, 1'b1);
        press_key(SC_F5, 1'b0);
        check_outputs({test_name, " nmi combo"}, 1'b1, 1'b0);
        release_key(SC_F5, 1'b0);
        check_outputs({test_name, " nmi released"}, 1'b1, 1'b1);
        release_key(SC_ALT, 1'b0);
        release_key(SC_CTRL, 1'b0);
        release_key(SC_Q, 1'b0);
        check_matrix({test_name, " all released"});
        press_key(SC_KPDOT, 1'b0);          // No modifiers held
        check_outputs({test_name, " kpdot alone"}, 1'b1, 1'b1);
        check_matrix({test_name, " kpdot alone"});
        release_key(SC_KPDOT, 1'b0);
        check_outputs({test_name, " kpdot released"}, 1'b1, 1'b1);
    endtask

    initial
    begin
        rst_n    = 1'b0;
        ps2_clk  = 1'b1;
        ps2_data = 1'b1;
        rows     = '1;
        clear_model();
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        repeat (4) @(negedge clk);

        plain_keys();
        shift_mapping();
        composite_keys();
        simultaneous_keys();
        corrupted_frames();
        system_combos();

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+src
src/ace_kbd_pkg.sv
src/ps2_rx.sv
src/scancode_decoder.sv
src/key_mapper.sv
src/key_matrix.sv
src/ace_keyboard.sv
verification/ace_keyboard_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the ace_keyboard testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -j 0 \
    --top-module ace_keyboard_tb \
    -f filelist.f \
    -o ace_keyboard_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/ace_keyboard_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation run ended with status $status"
    exit $status
fi

exit 0
